// ==== include/upsize_cfg.svh ====
// fixed 32 to 64 bit upsize with a 16 word FIFO; changing a width here needs matching RAM and lanes
`ifndef UPSIZE_CFG_SVH
`define UPSIZE_CFG_SVH

// ----------------------------------------------------------------------
// stream widths
// ----------------------------------------------------------------------

`define UPSIZE_S_DATA_W     32
`define UPSIZE_M_DATA_W     64
`define UPSIZE_BYTE_W       8

// input beats packed into one output word
`define UPSIZE_LANES        2

// ----------------------------------------------------------------------
// word FIFO
// ----------------------------------------------------------------------

// depth is 2**ptr width
`define UPSIZE_FIFO_PTR_W   4

`endif

// ==== source/axis_pkg.sv ====
// stream payload types; input carries no keep, output keep is only partial on a flushed word
`default_nettype none

`include "upsize_cfg.svh"

package axis_pkg;

    // one beat on the narrow input side
    typedef struct packed {
        logic [`UPSIZE_S_DATA_W-1:0]                data;
        logic                                       last;
    } in_beat_t;

    // one packed word on the wide output side
    typedef struct packed {
        logic [`UPSIZE_M_DATA_W-1:0]                data;
        logic [`UPSIZE_M_DATA_W/`UPSIZE_BYTE_W-1:0] keep;
        logic                                       last;
    } out_word_t;

endpackage

`default_nettype wire

// ==== source/fifo_pkg.sv ====
// FIFO bookkeeping types; counts need one bit more than the pointers to reach full depth
`default_nettype none

`include "upsize_cfg.svh"

package fifo_pkg;

    // RAM address
    typedef logic [`UPSIZE_FIFO_PTR_W-1:0] fifo_ptr_t;

    // 0 .. depth inclusive
    typedef logic [`UPSIZE_FIFO_PTR_W:0]   fifo_count_t;

    // ------------------------------------------------------------------
    // control to storage
    // ------------------------------------------------------------------

    typedef struct packed {
        logic      wr_en;
        fifo_ptr_t wr_addr;
        // RAM pop into the output register
        logic      rd_en;
        fifo_ptr_t rd_addr;
        // output register enable, clears it when rd_en is low
        logic      load;
    } store_cmd_t;

endpackage

`default_nettype wire

// ==== source/upsize_ctrl.sv ====
// single clock only; s_ready drops at 16 stored words even if the output side pops that cycle
`timescale 1ns/1ps
`default_nettype none

`include "upsize_cfg.svh"

module upsize_ctrl (
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  s_valid,
    input  logic                  s_last,
    output logic                  s_ready,

    output logic                  m_valid,
    input  logic                  m_ready,

    output logic                  lane_load,
    output logic                  lane_flush,
    output fifo_pkg::store_cmd_t  store_cmd,

    output fifo_pkg::fifo_count_t s_fifo_free_count,
    output fifo_pkg::fifo_count_t m_fifo_data_count
);

    localparam fifo_pkg::fifo_count_t DEPTH = fifo_pkg::fifo_count_t'(1 << `UPSIZE_FIFO_PTR_W);

    logic                  phase;
    fifo_pkg::fifo_ptr_t   wr_ptr;
    fifo_pkg::fifo_ptr_t   rd_ptr;
    fifo_pkg::fifo_count_t count;
    logic                  out_valid;

    logic                  s_take;
    logic                  m_take;
    logic                  wr_en;
    logic                  out_open;
    logic                  pop;

    // ------------------------------------------------------------------
    // handshake decisions
    // ------------------------------------------------------------------

    assign s_ready  = (count != DEPTH);
    assign s_take   = s_valid & s_ready;
    assign m_take   = out_valid & m_ready;

    // word completes on the second lane or on an early last
    assign wr_en    = s_take & (phase | s_last);

    // output register empty or being read this cycle
    assign out_open = ~out_valid | m_ready;
    assign pop      = (count != '0) & out_open;

    assign lane_load  = s_take & ~phase & ~s_last;
    // half word, no held lane
    assign lane_flush = s_take & ~phase & s_last;

    assign store_cmd.wr_en   = wr_en;
    assign store_cmd.wr_addr = wr_ptr;
    assign store_cmd.rd_en   = pop;
    assign store_cmd.rd_addr = rd_ptr;
    assign store_cmd.load    = pop | m_take;

    // ------------------------------------------------------------------
    // state
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (rst) begin
            phase     <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (s_take) begin
                phase <= ~phase & ~s_last;
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (out_open) begin
                out_valid <= pop;
            end
        end
    end

    assign m_valid           = out_valid;
    // output register not counted
    assign m_fifo_data_count = count;
    assign s_fifo_free_count = DEPTH - count;

endmodule

`default_nettype wire

// ==== source/lane_packer.sv ====
// endian must stay constant within a packet since both lanes are placed by the current value
`timescale 1ns/1ps
`default_nettype none

`include "upsize_cfg.svh"

module lane_packer (
    input  logic                aclk,
    input  logic                rst,
    input  logic                endian,
    input  axis_pkg::in_beat_t  s_beat,
    input  logic                lane_load,
    input  logic                lane_flush,
    output axis_pkg::out_word_t word
);

    localparam int LANE_W      = `UPSIZE_M_DATA_W / `UPSIZE_LANES;
    localparam int LANE_KEEP_W = LANE_W / `UPSIZE_BYTE_W;
    localparam logic [LANE_KEEP_W-1:0] KEEP_ALL = '1;

    logic [LANE_W-1:0]      held_data;
    logic [LANE_W-1:0]      first_data;
    logic [LANE_W-1:0]      second_data;
    logic [LANE_KEEP_W-1:0] second_keep;

    // first lane of a two beat word
    always_ff @(posedge aclk) begin
        if (rst) begin
            held_data <= '0;
        end else if (lane_load) begin
            held_data <= s_beat.data;
        end
    end

    // on a flush the current beat is the first lane and the second is empty
    always_comb begin
        first_data  = lane_flush ? s_beat.data : held_data;
        second_data = lane_flush ? '0 : s_beat.data;
        second_keep = lane_flush ? '0 : KEEP_ALL;

        // endian 1 puts the first beat in the upper half
        if (endian) begin
            word.data = {first_data, second_data};
            word.keep = {KEEP_ALL, second_keep};
        end else begin
            word.data = {second_data, first_data};
            word.keep = {second_keep, KEEP_ALL};
        end
        word.last = s_beat.last;
    end

endmodule

`default_nettype wire

// ==== source/fifo_store.sv ====
// no read-during-write check; control never writes and pops the same address on one edge
`timescale 1ns/1ps
`default_nettype none

`include "upsize_cfg.svh"

module fifo_store (
    input  logic                 aclk,
    input  axis_pkg::out_word_t  wr_word,
    input  fifo_pkg::store_cmd_t store_cmd,
    output axis_pkg::out_word_t  m_word
);

    localparam int DEPTH = 1 << `UPSIZE_FIFO_PTR_W;

    axis_pkg::out_word_t mem [DEPTH];

    // ------------------------------------------------------------------
    // word RAM
    // ------------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (store_cmd.wr_en) begin
            mem[store_cmd.wr_addr] <= wr_word;
        end
    end

    // ------------------------------------------------------------------
    // output register
    // ------------------------------------------------------------------

    // drained with nothing behind it, bus goes back to zero
    always_ff @(posedge aclk) begin
        if (store_cmd.load) begin
            if (store_cmd.rd_en) begin
                m_word <= mem[store_cmd.rd_addr];
            end else begin
                m_word <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/axis_upsize_fifo.sv ====
// one clock domain, 2 cycle minimum latency through an empty FIFO; counts exclude the output register
`timescale 1ns/1ps
`default_nettype none

module axis_upsize_fifo (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  endian,

    input  axis_pkg::in_beat_t    s_beat,
    input  logic                  s_valid,
    output logic                  s_ready,

    output axis_pkg::out_word_t   m_word,
    output logic                  m_valid,
    input  logic                  m_ready,

    output fifo_pkg::fifo_count_t s_fifo_free_count,
    output fifo_pkg::fifo_count_t m_fifo_data_count
);

    logic                 lane_load;
    logic                 lane_flush;
    fifo_pkg::store_cmd_t store_cmd;
    axis_pkg::out_word_t  packed_word;

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------

    upsize_ctrl u_ctrl (
        .aclk              (aclk),
        .rst               (rst),
        .s_valid           (s_valid),
        .s_last            (s_beat.last),
        .s_ready           (s_ready),
        .m_valid           (m_valid),
        .m_ready           (m_ready),
        .lane_load         (lane_load),
        .lane_flush        (lane_flush),
        .store_cmd         (store_cmd),
        .s_fifo_free_count (s_fifo_free_count),
        .m_fifo_data_count (m_fifo_data_count)
    );

    // ------------------------------------------------------------------
    // datapath, packer ahead of the FIFO
    // ------------------------------------------------------------------

    lane_packer u_packer (
        .aclk       (aclk),
        .rst        (rst),
        .endian     (endian),
        .s_beat     (s_beat),
        .lane_load  (lane_load),
        .lane_flush (lane_flush),
        .word       (packed_word)
    );

    fifo_store u_store (
        .aclk      (aclk),
        .wr_word   (packed_word),
        .store_cmd (store_cmd),
        .m_word    (m_word)
    );

endmodule

`default_nettype wire

// ==== test/tb_axis_upsize_fifo.sv ====
// reads test/upsize_stim.txt relative to the project root; endian only changes between packets
`timescale 1ns/1ps
`default_nettype none

`include "upsize_cfg.svh"

module tb_axis_upsize_fifo;

    localparam string STIM_FILE = "test/upsize_stim.txt";
    localparam fifo_pkg::fifo_count_t DEPTH = fifo_pkg::fifo_count_t'(1 << `UPSIZE_FIFO_PTR_W);
    localparam logic [1:0] MODE_FREE   = 2'd0;
    localparam logic [1:0] MODE_RANDOM = 2'd1;
    localparam logic [1:0] MODE_STALL  = 2'd2;

    // one entry of the input stream, either a beat or a back-pressure mode change
    typedef struct packed {
        logic               is_mode;
        logic [1:0]         mode;
        logic               endian;
        axis_pkg::in_beat_t beat;
    } item_t;

    logic                  aclk;
    logic                  rst;
    logic                  endian;
    axis_pkg::in_beat_t    s_beat;
    logic                  s_valid;
    logic                  s_ready;
    axis_pkg::out_word_t   m_word;
    logic                  m_valid;
    logic                  m_ready = 1'b0;
    fifo_pkg::fifo_count_t s_fifo_free_count;
    fifo_pkg::fifo_count_t m_fifo_data_count;

    item_t                 item_q[$];
    axis_pkg::out_word_t   exp_q[$];
    logic [31:0]           lfsr_state = 32'h7418_b52c;
    logic [1:0]            mode = MODE_FREE;
    logic                  ready_next = 1'b0;
    logic                  full_seen = 1'b0;
    logic                  had_stall = 1'b0;
    logic                  was_stalled = 1'b0;
    logic                  lane_odd = 1'b0;
    axis_pkg::out_word_t   held_word = '0;
    fifo_pkg::fifo_count_t exp_count;
    int                    num_beats = 0;
    int                    words_seen = 0;
    int                    words_written = 0;
    int                    words_taken = 0;
    int                    mismatch_errors = 0;
    int                    other_errors = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 200;

    axis_upsize_fifo u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        return lfsr_state[0];
    endfunction

    // expected word from the packing rules, pair low means a flushed half word
    function automatic axis_pkg::out_word_t model_word(input logic e,
            input logic [`UPSIZE_S_DATA_W-1:0] first, input logic [`UPSIZE_S_DATA_W-1:0] second,
            input logic pair, input logic last);
        axis_pkg::out_word_t         w;
        logic [`UPSIZE_S_DATA_W-1:0] other;
        other = pair ? second : '0;
        if (e) begin
            w.data = {first, other};
            w.keep = pair ? 8'hff : 8'hf0;
        end else begin
            w.data = {other, first};
            w.keep = pair ? 8'hff : 8'h0f;
        end
        w.last = last;
        return w;
    endfunction

    task automatic check_word(input string name, input axis_pkg::out_word_t exp,
            input axis_pkg::out_word_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %h keep %h last %h, got %h keep %h last %h",
                     name, exp.data, exp.keep, exp.last, act.data, act.keep, act.last);
        end
    endtask

    task automatic check_count(input string name, input fifo_pkg::fifo_count_t exp,
            input fifo_pkg::fifo_count_t act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_errors++;
            $display("MISMATCH %s: expected %h, got %h at %0t", name, exp, act, $time);
        end
    endtask

    // generated packet, data counts up from base
    task automatic add_packet(input logic e, input int beats, input logic [31:0] base);
        item_t it;
        for (int i = 0; i < beats; i++) begin
            it = '0;
            it.endian = e;
            it.beat.data = base + i;
            it.beat.last = (i == beats - 1);
            item_q.push_back(it);
            if (i % 2 == 1) begin
                exp_q.push_back(model_word(e, base + i - 1, base + i, 1'b1, it.beat.last));
            end else if (i == beats - 1) begin
                exp_q.push_back(model_word(e, base + i, '0, 1'b0, 1'b1));
            end
        end
        num_beats += beats;
    endtask

    task automatic load_stim();
        int                  fd;
        int                  n;
        int                  beats;
        string               line;
        logic [7:0]          tag;
        logic [63:0]         a;
        logic [63:0]         b;
        logic [63:0]         c;
        item_t               it;
        axis_pkg::out_word_t w;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("could not open the stimulus file %s", STIM_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2) begin
                continue;
            end
            tag = line.getc(0);
            it = '0;
            case (tag)
                "I": begin
                    n = $sscanf(line, "I %h %h %h", a, b, c);
                    it.endian = a[0];
                    it.beat.data = b[31:0];
                    it.beat.last = c[0];
                    item_q.push_back(it);
                    num_beats++;
                end
                "E": begin
                    n = $sscanf(line, "E %h %h %h", a, b, c);
                    w.data = a;
                    w.keep = b[7:0];
                    w.last = c[0];
                    exp_q.push_back(w);
                end
                "M": begin
                    n = $sscanf(line, "M %h", a);
                    it.is_mode = 1'b1;
                    it.mode = a[1:0];
                    item_q.push_back(it);
                end
                "G": begin
                    n = $sscanf(line, "G %h %d %h", a, beats, c);
                    add_packet(a[0], beats, c[31:0]);
                end
                "#": begin
                end
                default: begin
                    other_errors++;
                    $display("stimulus line not understood: %s", line);
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic drive_beat(input item_t it);
        logic accepted;
        if (mode == MODE_RANDOM) begin
            while (take_bit()) begin
                s_valid <= 1'b0;
                @(posedge aclk);
            end
        end
        s_valid <= 1'b1;
        s_beat  <= it.beat;
        endian  <= it.endian;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge aclk);
            accepted = s_ready;
            @(posedge aclk);
        end
    endtask

    // ------------------------------------------------------------------
    // output side, sampled at the falling edge
    // ------------------------------------------------------------------

    always @(negedge aclk) begin
        if (!rst) begin
            // RAM holds what was written minus what reached the output register
            exp_count = fifo_pkg::fifo_count_t'(words_written - words_taken - int'(m_valid));
            check_count("m_fifo_data_count", exp_count, m_fifo_data_count);
            check_count("s_fifo_free_count", DEPTH - exp_count, s_fifo_free_count);
            check_flag("s_ready", exp_count != DEPTH, s_ready);
            if (!s_ready && mode == MODE_STALL) begin
                full_seen = 1'b1;
            end
            if (was_stalled) begin
                check_flag("m_valid held", 1'b1, m_valid);
                check_word("m_word held", held_word, m_word);
            end
            was_stalled = m_valid && !m_ready;
            held_word = m_word;
            // beat taken on the coming edge, a word completes on a pair or on last
            if (s_valid && s_ready) begin
                if (lane_odd || s_beat.last) begin
                    words_written++;
                end
                lane_odd = !lane_odd && !s_beat.last;
            end
            if (m_valid && m_ready) begin
                words_taken++;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("output word %h arrived with no expected word left", m_word.data);
                end else begin
                    check_word("m_word", exp_q.pop_front(), m_word);
                    words_seen++;
                end
            end
            case (mode)
                MODE_RANDOM: ready_next = take_bit();
                MODE_STALL:  ready_next = full_seen;
                default:     ready_next = 1'b1;
            endcase
        end
    end

    always @(posedge aclk) begin
        if (rst) begin
            m_ready <= 1'b0;
        end else begin
            m_ready <= ready_next;
        end
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles: %0d mismatches, %0d other, %0d words outstanding",
                     cycle_count, mismatch_errors, other_errors, exp_q.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        rst = 1'b1;
        endian = 1'b0;
        s_beat = '0;
        s_valid = 1'b0;
        load_stim();
        cycle_limit = 20 * num_beats + 200;
        if (other_errors == 0) begin
            repeat (2) @(posedge aclk);
            rst <= 1'b0;
            @(negedge aclk);
            check_flag("m_valid", 1'b0, m_valid);
            check_flag("s_ready", 1'b1, s_ready);
            check_count("m_fifo_data_count", '0, m_fifo_data_count);
            check_count("s_fifo_free_count", DEPTH, s_fifo_free_count);
            @(posedge aclk);
            foreach (item_q[i]) begin
                if (item_q[i].is_mode) begin
                    mode = item_q[i].mode;
                    had_stall = had_stall | (item_q[i].mode == MODE_STALL);
                end else begin
                    drive_beat(item_q[i]);
                end
            end
            s_valid <= 1'b0;
            while (exp_q.size() != 0) begin
                @(posedge aclk);
            end
            repeat (4) @(posedge aclk);
            check_flag("m_valid", 1'b0, m_valid);
            check_count("m_fifo_data_count", '0, m_fifo_data_count);
            if (had_stall && !full_seen) begin
                other_errors++;
                $display("s_ready never dropped while the output was stalled");
            end
        end
        $display("errors: %0d mismatches, %0d other, %0d words checked",
                 mismatch_errors, other_errors, words_seen);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/upsize_stim.txt ====
# I endian data last : input beat, hex fields
# E data keep last : expected output word, hex fields
# M mode : 0 ready always, 1 random back-pressure, 2 stall until s_ready drops
# G endian beats base : generated packet, beats in decimal
M 0
# even packets, endian 0
I 0 a0000001 0
I 0 a0000002 1
E a0000002a0000001 ff 1
I 0 a0000003 0
I 0 a0000004 0
I 0 a0000005 0
I 0 a0000006 1
E a0000004a0000003 ff 0
E a0000006a0000005 ff 1
# same packets, endian 1
I 1 a0000001 0
I 1 a0000002 1
E a0000001a0000002 ff 1
G 1 4 a0000003
# odd and single beat packets
I 0 b0000001 0
I 0 b0000002 0
I 0 b0000003 1
E b0000002b0000001 ff 0
E 00000000b0000003 0f 1
I 1 b0000004 1
E b000000400000000 f0 1
I 0 b0000005 1
E 00000000b0000005 0f 1
M 2
G 0 40 c0000000
M 1
G 1 7 d0000000
G 0 12 e0000000
G 1 1 f0000000
I 0 b0000006 1
E 00000000b0000006 0f 1

// ==== tb.f ====
+incdir+include
source/axis_pkg.sv
source/fifo_pkg.sv
source/upsize_ctrl.sv
source/lane_packer.sv
source/fifo_store.sv
source/axis_upsize_fifo.sv
test/tb_axis_upsize_fifo.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing
TOP      := tb_axis_upsize_fifo
FILELIST := tb.f
BUILD    := build
LOG      := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
